// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = tb_fma
FILE_LIST = list.f

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: list.f
verilog/fma_pkg.sv
verilog/fma_operand_prep.sv
verilog/fma_mantissa_add.sv
verilog/fma_pipe_stage.sv
verilog/fma_normalize_round.sv
verilog/fma_unit.sv
tb/tb_clock_gen.sv
tb/tb_fma.sv

// File: tb/fma_stimulus.txt
# Columns: op op_mod a b c result status, all hex
# op 0 FMADD, 1 FNMSUB, 2 ADD, 3 MUL; status bits NV OF UF NX
0 0 4000 4200 3C00 4700 0
0 1 4000 4200 3C00 4500 0
1 0 4000 4200 3C00 C500 0
1 1 4000 4200 3C00 C700 0
0 1 3E00 3E00 4000 3400 0
0 1 3C01 3C01 3C00 1800 1
0 0 3E00 3E00 C080 0000 0
2 0 0000 3C00 1000 3C00 1
2 0 0000 3C01 1000 3C02 1
2 0 0000 4000 4200 4500 0
2 1 0000 4000 4200 BC00 0
3 0 4000 4200 4900 4600 0
3 0 4200 0000 4900 0000 0
0 0 7C01 3C00 3C00 7E00 8
0 0 3C00 FE05 3C00 7E00 0
0 0 7C00 0000 7E00 7E00 8
0 0 7C00 3C00 FC00 7E00 8
1 0 7C00 4000 3C00 FC00 0
2 0 0000 3C00 FC00 FC00 0
0 0 7BFF 4000 0000 7C00 5
0 0 0003 3800 0000 0002 3
0 0 0004 3800 0000 0002 0
0 0 1C00 1C00 0000 0100 0
0 0 1C00 1C01 0000 0100 3

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // 40 ns period
  localparam int HALF_PERIOD_NS = 20;

  // Starts low so the first rising edge lands at 20 ns
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: tb/tb_fma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fma;
  import fma_pkg::*;

  // Cycles allowed for any single handshake
  localparam int TIMEOUT_CYCLES = 64;
  localparam string STIM_FILE = "tb/fma_stimulus.txt";

  logic     clk;
  logic     rst;
  fp_word_t a;
  fp_word_t b;
  fp_word_t c;
  fma_op_e  op;
  logic     op_mod;
  logic     in_valid;
  logic     in_ready;
  fp_word_t result;
  status_t  status;
  logic     out_valid;
  logic     out_ready;

  // Vectors from the stimulus file
  logic [1:0] vec_op[$];
  logic       vec_mod[$];
  fp_word_t   vec_a[$];
  fp_word_t   vec_b[$];
  fp_word_t   vec_c[$];
  fp_word_t   vec_res[$];
  status_t    vec_stat[$];

  // Accepted items still in flight, oldest first
  int pend_idx[$];
  int pend_cycle[$];

  int   seed      = 32'h7411;
  int   cycle_cnt = 0;
  int   errors    = 0;
  int   timeouts  = 0;
  logic aborted   = 1'b0;

  tb_clock_gen u_clock_gen (
    .clk_o (clk)
  );

  fma_unit u_fma_unit (
    .clk_i       (clk),
    .rst_i       (rst),
    .a_i         (a),
    .b_i         (b),
    .c_i         (c),
    .op_i        (op),
    .op_mod_i    (op_mod),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .result_o    (result),
    .status_o    (status),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  // Cycle count moves on the falling edge, read on the rising edge
  always @(negedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ------------------------------------------------------------------
  // Stimulus file
  // ------------------------------------------------------------------
  task automatic load_vectors();
    int         fd;
    int         code;
    int         n;
    string      line;
    logic [1:0] f_op;
    logic       f_mod;
    fp_word_t   f_a, f_b, f_c, f_res;
    status_t    f_stat;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      aborted = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // Lines starting with # describe the columns
        if (code > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_mod, f_a, f_b, f_c, f_res,
                      f_stat);
          if (n == 7) begin
            vec_op.push_back(f_op);
            vec_mod.push_back(f_mod);
            vec_a.push_back(f_a);
            vec_b.push_back(f_b);
            vec_c.push_back(f_c);
            vec_res.push_back(f_res);
            vec_stat.push_back(f_stat);
          end
        end
      end
      $fclose(fd);
      if (vec_a.size() == 0) begin
        $display("The stimulus file holds no vectors");
        aborted = 1'b1;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Driver
  // ------------------------------------------------------------------
  task automatic drive_vectors();
    int   waited;
    logic accepted;
    for (int i = 0; i < vec_a.size() && !aborted; i++) begin
      @(negedge clk);
      a        = vec_a[i];
      b        = vec_b[i];
      c        = vec_c[i];
      op       = fma_op_e'(vec_op[i]);
      op_mod   = vec_mod[i];
      in_valid = 1'b1;
      accepted = 1'b0;
      waited   = 0;
      // Hold the vector until the DUT takes it
      while (!accepted && waited < TIMEOUT_CYCLES) begin
        @(posedge clk);
        if (in_ready) begin
          accepted = 1'b1;
          pend_idx.push_back(i);
          pend_cycle.push_back(cycle_cnt);
        end else begin
          waited++;
        end
      end
      if (!accepted) begin
        $display("Timeout: vector %0d was not accepted within %0d cycles", i, TIMEOUT_CYCLES);
        timeouts++;
        aborted = 1'b1;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Checker
  // ------------------------------------------------------------------
  task automatic check_results(input logic random_ready);
    int          got;
    int          waited;
    int          idx;
    int          latency;
    logic        taken;
    logic [31:0] rnd;
    got = 0;
    while (got < vec_a.size() && !aborted) begin
      taken  = 1'b0;
      waited = 0;
      while (!taken && waited < TIMEOUT_CYCLES) begin
        @(negedge clk);
        if (random_ready) begin
          rnd       = $random(seed);
          out_ready = rnd[0];
        end else begin
          out_ready = 1'b1;
        end
        @(posedge clk);
        if (out_valid && out_ready) begin
          taken = 1'b1;
        end else begin
          waited++;
        end
      end
      if (!taken) begin
        $display("Timeout: no result for output %0d within %0d cycles", got, TIMEOUT_CYCLES);
        timeouts++;
        aborted = 1'b1;
      end else begin
        assert (pend_idx.size() > 0) else begin
          $display("[FAIL] %0t output %h with no vector in flight", $time, result);
          errors++;
        end
        if (pend_idx.size() > 0) begin
          idx     = pend_idx.pop_front();
          latency = cycle_cnt - pend_cycle.pop_front();
          assert (result == vec_res[idx]) else begin
            $display("[FAIL] %0t vector %0d result %h expected %h", $time, idx, result,
                     vec_res[idx]);
            errors++;
          end
          assert (status == vec_stat[idx]) else begin
            $display("[FAIL] %0t vector %0d status %b expected %b", $time, idx, status,
                     vec_stat[idx]);
            errors++;
          end
          // Fixed latency only holds without back-pressure
          if (!random_ready) begin
            assert (latency == 2) else begin
              $display("[FAIL] %0t vector %0d latency %0d expected 2", $time, idx, latency);
              errors++;
            end
          end
        end
        got++;
      end
    end
  endtask

  // Nothing may come out once every vector is back
  task automatic check_idle();
    repeat (4) begin
      @(posedge clk);
      assert (!out_valid) else begin
        $display("[FAIL] %0t extra output %h after the last vector", $time, result);
        errors++;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst       = 1'b1;
    a         = '0;
    b         = '0;
    c         = '0;
    op        = FMADD;
    op_mod    = 1'b0;
    // Offer an item and stall the sink while in reset
    in_valid  = 1'b1;
    out_ready = 1'b0;
    load_vectors();
    // Two rising edges under reset
    repeat (2) @(negedge clk);
    rst       = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    @(posedge clk);
    assert (!out_valid && in_ready) else begin
      $display("[FAIL] %0t after reset out_valid %b in_ready %b", $time, out_valid, in_ready);
      errors++;
    end
    // Pass one with the sink always ready
    if (!aborted) begin
      fork
        drive_vectors();
        check_results(1'b0);
      join
    end
    if (!aborted) begin
      check_idle();
    end
    // Pass two under random back-pressure
    if (!aborted) begin
      fork
        drive_vectors();
        check_results(1'b1);
      join
    end
    if (!aborted) begin
      check_idle();
    end
    $display("Summary: %0d vectors per pass, %0d errors, %0d timeouts", vec_a.size(), errors,
             timeouts);
    if (errors == 0 && timeouts == 0 && !aborted) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/fma_mantissa_add.sv
`timescale 1ns/1ps
`default_nettype none

module fma_mantissa_add (
  input  fma_pkg::fp_word_t op_a_i,
  input  fma_pkg::fp_word_t op_b_i,
  input  fma_pkg::fp_word_t op_c_i,
  input  logic              a_normal_i,
  input  logic              b_normal_i,
  input  logic              c_normal_i,
  input  logic              a_zero_i,
  input  logic              b_zero_i,
  input  logic              a_subnormal_i,
  input  logic              b_subnormal_i,
  output logic              eff_sub_o,
  output fma_pkg::exp_t     exp_prod_o,
  output fma_pkg::exp_t     exp_diff_o,
  output fma_pkg::exp_t     tent_exp_o,
  output fma_pkg::shamt_t   addend_shamt_o,
  output logic              sticky_o,
  output fma_pkg::sum_t     sum_o,
  output logic              final_sign_o
);
  import fma_pkg::*;

  exp_t                         exp_a, exp_b, exp_c, exp_addend;
  logic                         tent_sign;
  logic [PREC_BITS-1:0]         man_a, man_b, man_c;
  logic [2*PREC_BITS-1:0]       product;
  sum_t                         product_shifted;
  logic [SUM_WIDTH+PREC_BITS-1:0] addend_wide;
  sum_t                         addend_shifted;
  logic                         inject_carry;
  logic [SUM_WIDTH:0]           sum_raw;
  logic                         sum_carry;

  // ------------------------------------------------------------------
  // Exponent path
  // ------------------------------------------------------------------
  assign exp_a = exp_t'({2'b00, op_a_i[MAN_BITS +: EXP_BITS]});
  assign exp_b = exp_t'({2'b00, op_b_i[MAN_BITS +: EXP_BITS]});
  assign exp_c = exp_t'({2'b00, op_c_i[MAN_BITS +: EXP_BITS]});

  // Subnormals act as exponent 1, exponents stay biased
  assign exp_addend = exp_c + exp_t'(!c_normal_i);
  // Zero product gets the smallest exponent
  assign exp_prod_o = (a_zero_i || b_zero_i) ? exp_t'(2 - BIAS)
                    : exp_a + exp_t'(a_subnormal_i) + exp_b + exp_t'(b_subnormal_i)
                      - exp_t'(BIAS);
  assign exp_diff_o = exp_addend - exp_prod_o;
  assign tent_exp_o = (exp_diff_o > 0) ? exp_addend : exp_prod_o;

  // Right shift of the addend, saturated at both ends
  always_comb begin
    if (exp_diff_o <= exp_t'(-2 * PREC_BITS - 1)) begin
      // Addend lands in the sticky bit only
      addend_shamt_o = shamt_t'(SUM_WIDTH);
    end else if (exp_diff_o <= exp_t'(PREC_BITS + 2)) begin
      addend_shamt_o = shamt_t'(exp_t'(PREC_BITS + 3) - exp_diff_o);
    end else begin
      // Product lands in the sticky bit only
      addend_shamt_o = '0;
    end
  end

  // ------------------------------------------------------------------
  // Product and addend alignment
  // ------------------------------------------------------------------
  assign man_a = {a_normal_i, op_a_i[MAN_BITS-1:0]};
  assign man_b = {b_normal_i, op_b_i[MAN_BITS-1:0]};
  assign man_c = {c_normal_i, op_c_i[MAN_BITS-1:0]};

  assign product = man_a * man_b;
  // Two low bits for round and sticky
  assign product_shifted = sum_t'({product, 2'b00});

  // Up to PREC_BITS bits drop off the end into the sticky
  assign addend_wide = {man_c, {SUM_WIDTH{1'b0}}} >> addend_shamt_o;
  assign sticky_o    = |addend_wide[PREC_BITS-1:0];

  assign tent_sign      = op_a_i[15] ^ op_b_i[15];
  assign eff_sub_o      = tent_sign ^ op_c_i[15];
  assign addend_shifted = eff_sub_o ? ~addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS]
                                    : addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS];
  // Sticky bits already borrow the one from the two's complement
  assign inject_carry   = eff_sub_o & ~sticky_o;

  // ------------------------------------------------------------------
  // Adder and sign fix
  // ------------------------------------------------------------------
  assign sum_raw   = {1'b0, product_shifted} + {1'b0, addend_shifted}
                   + (SUM_WIDTH+1)'(inject_carry);
  assign sum_carry = sum_raw[SUM_WIDTH];

  // No carry out on subtraction means a negative sum
  assign sum_o = (eff_sub_o && !sum_carry) ? sum_t'(~sum_raw[SUM_WIDTH-1:0] + 1'b1)
                                           : sum_raw[SUM_WIDTH-1:0];

  // Sign of the product unless the subtraction went the other way
  assign final_sign_o = eff_sub_o ? (sum_carry == tent_sign) : tent_sign;

endmodule

`default_nettype wire

// File: verilog/fma_normalize_round.sv
`timescale 1ns/1ps
`default_nettype none

module fma_normalize_round (
  input  logic              eff_sub_i,
  input  fma_pkg::exp_t     exp_prod_i,
  input  fma_pkg::exp_t     exp_diff_i,
  input  fma_pkg::exp_t     tent_exp_i,
  input  fma_pkg::shamt_t   addend_shamt_i,
  input  logic              sticky_i,
  input  fma_pkg::sum_t     sum_i,
  input  logic              final_sign_i,
  input  logic              is_special_i,
  input  fma_pkg::fp_word_t special_result_i,
  input  fma_pkg::status_t  special_status_i,
  output fma_pkg::fp_word_t result_o,
  output fma_pkg::status_t  status_o
);
  import fma_pkg::*;

  logic [LOWER_SUM_WIDTH-1:0]   sum_lower;
  logic [LZC_WIDTH-1:0]         lzc_cnt;
  logic                         lzc_zero;
  exp_t                         lzc_exp;
  shamt_t                       norm_shamt;
  exp_t                         norm_exp;
  logic [SUM_WIDTH:0]           sum_shifted;
  logic [PREC_BITS:0]           final_man;
  logic [LOWER_SUM_WIDTH-1:0]   sticky_bits;
  exp_t                         final_exp;
  logic                         sticky_norm;
  logic                         of_before, of_after, uf_after;
  logic [EXP_BITS+MAN_BITS-1:0] pre_abs, rounded_abs;
  logic [1:0]                   round_sticky;
  logic                         round_up;
  logic                         exact_zero;
  logic                         rounded_sign;
  logic                         nx;

  // ------------------------------------------------------------------
  // Leading zero count
  // ------------------------------------------------------------------
  assign sum_lower = sum_i[LOWER_SUM_WIDTH-1:0];

  // Highest set bit wins
  always_comb begin
    lzc_cnt = '0;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (sum_lower[i]) begin
        lzc_cnt = LZC_WIDTH'(LOWER_SUM_WIDTH - 1 - i);
      end
    end
  end

  assign lzc_zero = ~|sum_lower;
  assign lzc_exp  = exp_t'({2'b00, lzc_cnt});

  // ------------------------------------------------------------------
  // Normalization
  // ------------------------------------------------------------------
  always_comb begin
    if ((exp_diff_i <= 0) || (eff_sub_i && (exp_diff_i <= 2))) begin
      // Product anchored or cancelling, LZC decides
      if ((exp_prod_i - lzc_exp + 1 >= 0) && !lzc_zero) begin
        norm_shamt = shamt_t'(PREC_BITS + 2) + shamt_t'(lzc_cnt);
        norm_exp   = exp_t'(exp_prod_i - lzc_exp + 1);
      end else begin
        // Subnormal result, shift stops at the minimum exponent
        norm_shamt = shamt_t'(exp_t'(PREC_BITS + 2) + exp_prod_i);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = addend_shamt_i;
      norm_exp   = tent_exp_i;
    end
  end

  assign sum_shifted = {1'b0, sum_i} << norm_shamt;

  // Leading one may still sit one place off
  always_comb begin
    {final_man, sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_man, sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                = norm_exp + exp_t'(1);
    end else if (!sum_shifted[SUM_WIDTH-1]) begin
      if (norm_exp > 1) begin
        {final_man, sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
        final_exp                = norm_exp - exp_t'(1);
      end else begin
        final_exp = '0;
      end
    end
  end

  assign sticky_norm = (|sticky_bits) | sticky_i;

  // ------------------------------------------------------------------
  // Round to nearest, ties to even
  // ------------------------------------------------------------------
  assign of_before = final_exp >= exp_t'(2**EXP_BITS - 1);

  // Overflow saturates to max normal with round and sticky forced
  assign pre_abs = of_before ? {EXP_BITS'(2**EXP_BITS - 2), {MAN_BITS{1'b1}}}
                             : {final_exp[EXP_BITS-1:0], final_man[MAN_BITS:1]};
  assign round_sticky = of_before ? 2'b11 : {final_man[0], sticky_norm};

  assign round_up    = round_sticky[1] & (round_sticky[0] | pre_abs[0]);
  // Carry may run into the exponent and reach infinity
  assign rounded_abs = pre_abs + (EXP_BITS+MAN_BITS)'(round_up);

  // Exact cancellation gives +0
  assign exact_zero   = (pre_abs == '0) && (round_sticky == 2'b00);
  assign rounded_sign = (exact_zero && eff_sub_i) ? 1'b0 : final_sign_i;

  assign of_after = &rounded_abs[MAN_BITS +: EXP_BITS];
  assign uf_after = ~|rounded_abs[MAN_BITS +: EXP_BITS];
  assign nx       = (|round_sticky) | of_before | of_after;

  // ------------------------------------------------------------------
  // Result select
  // ------------------------------------------------------------------
  assign result_o = is_special_i ? special_result_i : {rounded_sign, rounded_abs};
  // Tiny results flag underflow only when inexact
  assign status_o = is_special_i ? special_status_i
                                 : {1'b0, of_before | of_after, uf_after & nx, nx};

endmodule

`default_nettype wire

// File: verilog/fma_operand_prep.sv
`timescale 1ns/1ps
`default_nettype none

module fma_operand_prep (
  input  logic              [15:0] a_i,
  input  logic              [15:0] b_i,
  input  logic              [15:0] c_i,
  input  fma_pkg::fma_op_e         op_i,
  input  logic                     op_mod_i,
  output fma_pkg::fp_word_t        op_a_o,
  output fma_pkg::fp_word_t        op_b_o,
  output fma_pkg::fp_word_t        op_c_o,
  output logic                     a_normal_o,
  output logic                     b_normal_o,
  output logic                     c_normal_o,
  output logic                     a_zero_o,
  output logic                     b_zero_o,
  output logic                     a_subnormal_o,
  output logic                     b_subnormal_o,
  output logic                     is_special_o,
  output fma_pkg::fp_word_t        special_result_o,
  output fma_pkg::status_t         special_status_o
);
  import fma_pkg::*;

  fp_word_t   raw [3];
  logic [2:0] is_zero, is_sub, is_norm, is_inf, is_nan, is_snan;
  // Classes after the operation adjustment
  logic       a_norm, a_zero, a_sub, a_inf, a_nan, a_snan;
  logic       c_norm, c_inf, c_nan, c_snan;
  logic       eff_sub;

  assign raw[0] = a_i;
  assign raw[1] = b_i;
  assign raw[2] = c_i;

  // ------------------------------------------------------------------
  // Operand classification
  // ------------------------------------------------------------------
  for (genvar i = 0; i < 3; i++) begin : gen_classify
    logic exp_ones;
    logic exp_zero;
    logic man_zero;
    assign exp_ones   = &raw[i][MAN_BITS +: EXP_BITS];
    assign exp_zero   = ~|raw[i][MAN_BITS +: EXP_BITS];
    assign man_zero   = ~|raw[i][MAN_BITS-1:0];
    assign is_zero[i] = exp_zero & man_zero;
    assign is_sub[i]  = exp_zero & ~man_zero;
    assign is_norm[i] = ~exp_zero & ~exp_ones;
    assign is_inf[i]  = exp_ones & man_zero;
    assign is_nan[i]  = exp_ones & ~man_zero;
    // Quiet bit is the mantissa MSB
    assign is_snan[i] = is_nan[i] & ~raw[i][MAN_BITS-1];
  end

  // ------------------------------------------------------------------
  // Operation adjustment
  // ------------------------------------------------------------------
  always_comb begin
    op_a_o = a_i;
    op_b_o = b_i;
    // op_mod always flips the addend sign
    op_c_o = {c_i[15] ^ op_mod_i, c_i[14:0]};
    {a_norm, a_zero, a_sub} = {is_norm[0], is_zero[0], is_sub[0]};
    {a_inf, a_nan, a_snan}  = {is_inf[0], is_nan[0], is_snan[0]};
    {c_norm, c_inf, c_nan, c_snan} = {is_norm[2], is_inf[2], is_nan[2], is_snan[2]};
    case (op_i)
      // Negated product
      FNMSUB: op_a_o[15] = ~a_i[15];
      // Multiplicand becomes +1.0
      ADD: begin
        op_a_o = {1'b0, EXP_BITS'(BIAS), MAN_BITS'(0)};
        {a_norm, a_zero, a_sub, a_inf, a_nan, a_snan} = 6'b100000;
      end
      // Addend becomes -0
      MUL: begin
        op_c_o = {1'b1, 15'h0000};
        {c_norm, c_inf, c_nan, c_snan} = 4'b0000;
      end
      default: ;
    endcase
  end

  assign a_normal_o    = a_norm;
  assign b_normal_o    = is_norm[1];
  assign c_normal_o    = c_norm;
  assign a_zero_o      = a_zero;
  assign b_zero_o      = is_zero[1];
  assign a_subnormal_o = a_sub;
  assign b_subnormal_o = is_sub[1];

  // Product and addend signs differ
  assign eff_sub = op_a_o[15] ^ op_b_o[15] ^ op_c_o[15];

  // ------------------------------------------------------------------
  // Special cases, highest priority first
  // ------------------------------------------------------------------
  always_comb begin
    is_special_o     = 1'b0;
    special_result_o = QNAN;
    special_status_o = '0;
    if ((a_inf && is_zero[1]) || (a_zero && is_inf[1])) begin
      // inf * 0 is invalid even with a quiet NaN addend
      is_special_o        = 1'b1;
      special_status_o[3] = 1'b1;
    end else if (a_nan || is_nan[1] || c_nan) begin
      is_special_o        = 1'b1;
      special_status_o[3] = a_snan | is_snan[1] | c_snan;
    end else if (a_inf || is_inf[1] || c_inf) begin
      is_special_o = 1'b1;
      if ((a_inf || is_inf[1]) && c_inf && eff_sub) begin
        // inf - inf
        special_status_o[3] = 1'b1;
      end else if (a_inf || is_inf[1]) begin
        special_result_o = {op_a_o[15] ^ op_b_o[15], {EXP_BITS{1'b1}}, MAN_BITS'(0)};
      end else begin
        special_result_o = {op_c_o[15], {EXP_BITS{1'b1}}, MAN_BITS'(0)};
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fma_pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fma_pipe_stage #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             ready_o,
  input  logic             ready_i,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o
);

  logic             valid_q;
  logic [WIDTH-1:0] data_q;

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: verilog/fma_pkg.sv
`default_nettype none

package fma_pkg;

  // ------------------------------------------------------------------
  // binary16 format
  // ------------------------------------------------------------------
  localparam int EXP_BITS  = 5;
  localparam int MAN_BITS  = 10;
  localparam int BIAS      = 15;
  // Precision includes the hidden bit
  localparam int PREC_BITS = MAN_BITS + 1;

  // ------------------------------------------------------------------
  // Internal data path widths
  // ------------------------------------------------------------------
  // Product plus aligned addend, with guard and round room
  localparam int SUM_WIDTH       = 3 * PREC_BITS + 4;
  // Low part of the sum searched for cancellation
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;
  localparam int LZC_WIDTH       = $clog2(LOWER_SUM_WIDTH);
  // Two extra bits keep the biased exponent signed and free of wrap
  localparam int EXP_WIDTH       = EXP_BITS + 2;
  localparam int SHAMT_WIDTH     = $clog2(SUM_WIDTH);

  typedef logic [EXP_BITS+MAN_BITS:0]  fp_word_t;
  typedef logic signed [EXP_WIDTH-1:0] exp_t;
  typedef logic [SHAMT_WIDTH-1:0]      shamt_t;
  typedef logic [SUM_WIDTH-1:0]        sum_t;
  // NV, OF, UF, NX
  typedef logic [3:0]                  status_t;

  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } fma_op_e;

  // Canonical quiet NaN
  localparam fp_word_t QNAN = 16'h7E00;

  // Mid stage bundle: sub flag, three exponents, shift, sticky, sum,
  // sign, special flag, special result and status
  localparam int MID_WIDTH = 1 + 3 * EXP_WIDTH + SHAMT_WIDTH + 1 + SUM_WIDTH + 1
                             + 1 + $bits(fp_word_t) + $bits(status_t);

endpackage

`default_nettype wire

// File: verilog/fma_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fma_unit (
  input  logic              clk_i,
  input  logic              rst_i,
  input  fma_pkg::fp_word_t a_i,
  input  fma_pkg::fp_word_t b_i,
  input  fma_pkg::fp_word_t c_i,
  input  fma_pkg::fma_op_e  op_i,
  input  logic              op_mod_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output fma_pkg::fp_word_t result_o,
  output fma_pkg::status_t  status_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);
  import fma_pkg::*;

  // Prep to adder
  fp_word_t op_a, op_b, op_c;
  logic     a_normal, b_normal, c_normal, a_zero, b_zero, a_sub, b_sub;
  // Fields entering the mid stage
  logic     is_special, eff_sub, sticky, final_sign;
  fp_word_t special_result;
  status_t  special_status;
  exp_t     exp_prod, exp_diff, tent_exp;
  shamt_t   addend_shamt;
  sum_t     sum;
  // Fields leaving the mid stage
  logic     is_special_q, eff_sub_q, sticky_q, final_sign_q;
  fp_word_t special_result_q;
  status_t  special_status_q;
  exp_t     exp_prod_q, exp_diff_q, tent_exp_q;
  shamt_t   addend_shamt_q;
  sum_t     sum_q;
  logic [MID_WIDTH-1:0] mid_data_q;
  logic     mid_valid, out_ready;
  // Output stage
  fp_word_t result_d;
  status_t  status_d;

  fma_operand_prep u_operand_prep (
    .a_i              (a_i),
    .b_i              (b_i),
    .c_i              (c_i),
    .op_i             (op_i),
    .op_mod_i         (op_mod_i),
    .op_a_o           (op_a),
    .op_b_o           (op_b),
    .op_c_o           (op_c),
    .a_normal_o       (a_normal),
    .b_normal_o       (b_normal),
    .c_normal_o       (c_normal),
    .a_zero_o         (a_zero),
    .b_zero_o         (b_zero),
    .a_subnormal_o    (a_sub),
    .b_subnormal_o    (b_sub),
    .is_special_o     (is_special),
    .special_result_o (special_result),
    .special_status_o (special_status)
  );

  fma_mantissa_add u_mantissa_add (
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .op_c_i         (op_c),
    .a_normal_i     (a_normal),
    .b_normal_i     (b_normal),
    .c_normal_i     (c_normal),
    .a_zero_i       (a_zero),
    .b_zero_i       (b_zero),
    .a_subnormal_i  (a_sub),
    .b_subnormal_i  (b_sub),
    .eff_sub_o      (eff_sub),
    .exp_prod_o     (exp_prod),
    .exp_diff_o     (exp_diff),
    .tent_exp_o     (tent_exp),
    .addend_shamt_o (addend_shamt),
    .sticky_o       (sticky),
    .sum_o          (sum),
    .final_sign_o   (final_sign)
  );

  // ------------------------------------------------------------------
  // Register after the adder
  // ------------------------------------------------------------------
  fma_pipe_stage #(
    .WIDTH (MID_WIDTH)
  ) u_mid_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (in_valid_i),
    .data_i  ({eff_sub, exp_prod, exp_diff, tent_exp, addend_shamt, sticky, sum,
               final_sign, is_special, special_result, special_status}),
    .ready_o (in_ready_o),
    .ready_i (out_ready),
    .valid_o (mid_valid),
    .data_o  (mid_data_q)
  );

  assign {eff_sub_q, exp_prod_q, exp_diff_q, tent_exp_q, addend_shamt_q, sticky_q, sum_q,
          final_sign_q, is_special_q, special_result_q, special_status_q} = mid_data_q;

  fma_normalize_round u_normalize_round (
    .eff_sub_i        (eff_sub_q),
    .exp_prod_i       (exp_prod_q),
    .exp_diff_i       (exp_diff_q),
    .tent_exp_i       (tent_exp_q),
    .addend_shamt_i   (addend_shamt_q),
    .sticky_i         (sticky_q),
    .sum_i            (sum_q),
    .final_sign_i     (final_sign_q),
    .is_special_i     (is_special_q),
    .special_result_i (special_result_q),
    .special_status_i (special_status_q),
    .result_o         (result_d),
    .status_o         (status_d)
  );

  // Output register, result over status
  fma_pipe_stage #(
    .WIDTH ($bits(fp_word_t) + $bits(status_t))
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mid_valid),
    .data_i  ({result_d, status_d}),
    .ready_o (out_ready),
    .ready_i (out_ready_i),
    .valid_o (out_valid_o),
    .data_o  ({result_o, status_o})
  );

endmodule

`default_nettype wire
